//--- files.f
+incdir+include
design/fetch_pkg.sv
design/fetch_ifu.sv
design/icache.sv
design/icache_refill.sv
design/fetch_top.sv
verif/axi_rom_model.sv
verif/fetch_tb.sv

//--- run.sh
#!/bin/sh
# build and run the fetch testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -f files.f --top-module fetch_tb -Mdir obj_dir -o fetch_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/fetch_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" "$LOG"; then
  exit 1
fi
exit 0

//--- verif/fetch_tb.sv
`timescale 1ns/10ps

`include "fetch_defines.svh"

module fetch_tb;

  localparam int HALF_PERIOD   = 50;
  localparam int RESET_CYCLES  = 16;
  localparam int SEQ_FETCHES   = 64;
  localparam int RAND_FETCHES  = 40;
  localparam int TOTAL_FETCHES = 2 * SEQ_FETCHES + 2 * RAND_FETCHES;
  localparam int WATCHDOG      = RESET_CYCLES + 400 * TOTAL_FETCHES;
  localparam int OFFSET_W      = $clog2(`ICACHE_WORDS) + 2;
  localparam int TAG_LSB       = OFFSET_W + `ICACHE_INDEX_W;
  localparam int LINES         = 1 << `ICACHE_INDEX_W;
  localparam logic [`AXI_ID_W-1:0] BURST_ID = 4'h9;

  logic                  clk;
  logic                  nrst;
  fetch_pkg::fetch_req_t i_req;
  logic                  i_req_valid;
  logic                  o_req_ready;
  fetch_pkg::fetch_rsp_t o_rsp;
  logic                  o_rsp_valid;
  logic                  i_rsp_ready;
  logic                  i_flush;
  fetch_pkg::axi_ar_t    o_ar;
  logic                  o_ar_valid;
  logic                  i_ar_ready;
  fetch_pkg::axi_r_t     i_r;
  logic                  i_r_valid;
  logic                  o_r_ready;

  logic [31:0]      exp_pc_q [$];  // PCs waiting for their response
  logic [LINES-1:0] shadow_valid;
  logic [31:0]      shadow_tag [LINES];
  logic             bp_enable = 1'b0;
  int               err_count = 0;
  int               ar_count = 0;
  int               pred_misses = 0;
  int               tests_run = 0;
  int               tests_failed = 0;
  int               base_err;
  int               base_ar;
  int               base_pred;

  fetch_top #(
    .AXI_ID (BURST_ID)
  ) fetch_top_i (.*);

  axi_rom_model axi_rom_model_i (
    .clk        (clk),
    .nrst       (nrst),
    .i_ar       (o_ar),
    .i_ar_valid (o_ar_valid),
    .o_ar_ready (i_ar_ready),
    .o_r        (i_r),
    .o_r_valid  (i_r_valid),
    .i_r_ready  (o_r_ready)
  );

  function automatic logic [31:0] expected_word(input logic [31:0] pc);
    logic [31:0] x;
    x = {pc[31:2], 2'b00} ^ 32'h1357_9bdf;
    return {x[26:0], x[31:27]};
  endfunction

  // a miss fills the line, so the table is updated here
  function automatic logic predict_miss(input logic [31:0] pc);
    int          idx;
    logic [31:0] tag;
    idx = int'(pc[OFFSET_W +: `ICACHE_INDEX_W]);
    tag = pc >> TAG_LSB;
    if (shadow_valid[idx] && shadow_tag[idx] == tag) begin
      return 1'b0;
    end
    shadow_valid[idx] = 1'b1;
    shadow_tag[idx]   = tag;
    return 1'b1;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic issue_fetch(input logic [31:0] pc);
    i_req.pc    = pc;
    i_req_valid = 1'b1;
    exp_pc_q.push_back(pc);
    if (predict_miss(pc)) begin
      pred_misses++;
    end
    while (!o_req_ready) @(negedge clk);
    @(negedge clk);  // accepted at the edge just passed
    i_req_valid = 1'b0;
  endtask

  task automatic begin_test();
    base_err  = err_count;
    base_ar   = ar_count;
    base_pred = pred_misses;
  endtask

  task automatic end_test(input string name);
    while (exp_pc_q.size() != 0) @(negedge clk);
    @(negedge clk);
    check_value("AR handshakes", 64'(ar_count - base_ar), 64'(pred_misses - base_pred));
    tests_run++;
    if (err_count != base_err) begin
      tests_failed++;
    end
    $display("test %-12s %s, %0d errors", name, (err_count == base_err) ? "pass" : "fail",
             err_count - base_err);
  endtask

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  initial begin : watchdog
    repeat (WATCHDOG) @(posedge clk);
    $display("timeout: fetches still pending after %0d cycles", WATCHDOG);
    $display("Test failed");
    $finish;
  end

  initial begin : monitor_ar
    forever begin
      @(posedge clk);
      if (nrst && o_ar_valid && i_ar_ready) begin
        ar_count++;
        check_value("o_ar.len", 64'(o_ar.len), 64'(`ICACHE_WORDS - 1));
        check_value("o_ar.burst", 64'(o_ar.burst), 64'(1));  // INCR
        check_value("o_ar.size", 64'(o_ar.size), 64'(2));  // four byte beats
        check_value("o_ar.id", 64'(o_ar.id), 64'(BURST_ID));
        check_value("o_ar.addr offset", 64'(o_ar.addr[OFFSET_W-1:0]), 64'(0));
        check_value("o_r_ready", 64'(o_r_ready), 64'(0));  // no burst in flight yet
      end
    end
  end

  // picks i_rsp_ready for the coming edge and checks what that edge takes
  initial begin : compare_rsp
    logic                  held;
    fetch_pkg::fetch_rsp_t held_rsp;
    int                    hold_cnt;
    logic [31:0]           pc;
    held        = 1'b0;
    hold_cnt    = 0;
    i_rsp_ready = 1'b1;
    forever begin
      @(negedge clk);
      if (bp_enable && o_rsp_valid && hold_cnt > 0) begin
        i_rsp_ready = 1'b0;
        hold_cnt--;
      end else begin
        i_rsp_ready = 1'b1;
      end
      if (held && !o_rsp_valid) begin
        $display("ERROR at %0t: o_rsp_valid dropped before the response was taken", $time);
        err_count++;
      end else if (held) begin
        check_value("o_rsp (held)", 64'(o_rsp), 64'(held_rsp));
      end
      held = 1'b0;
      if (o_rsp_valid) begin
        check_value("o_req_ready", 64'(o_req_ready), 64'(0));
        if (!i_rsp_ready) begin
          held     = 1'b1;
          held_rsp = o_rsp;
        end else if (exp_pc_q.size() == 0) begin
          $display("ERROR at %0t: response arrived with no fetch pending", $time);
          err_count++;
        end else begin
          pc = exp_pc_q.pop_front();
          check_value("o_rsp.pc", 64'(o_rsp.pc), 64'(pc));
          check_value("o_rsp.inst", 64'(o_rsp.inst), 64'(expected_word(pc)));
          if (bp_enable) begin
            hold_cnt = $urandom_range(8, 1);
          end
        end
      end
    end
  end

  initial begin : run_tests
    int unsigned tag;
    int unsigned idx;
    void'($urandom(32'h79f0_3db6));
    nrst         = 1'b0;
    i_req        = '0;
    i_req_valid  = 1'b0;
    i_flush      = 1'b0;
    shadow_valid = '0;

    begin_test();
    repeat (RESET_CYCLES) begin
      @(negedge clk);
      check_value("o_rsp_valid", 64'(o_rsp_valid), 64'(0));
      check_value("o_ar_valid", 64'(o_ar_valid), 64'(0));
      check_value("o_req_ready", 64'(o_req_ready), 64'(0));
      check_value("o_r_ready", 64'(o_r_ready), 64'(0));
    end
    nrst = 1'b1;
    @(negedge clk);
    check_value("o_rsp_valid", 64'(o_rsp_valid), 64'(0));
    check_value("o_ar_valid", 64'(o_ar_valid), 64'(0));
    end_test("reset");

    begin_test();
    for (int i = 0; i < SEQ_FETCHES; i++) begin
      issue_fetch(32'h1000 + 32'(i * 4));
    end
    end_test("sequential");

    begin_test();
    for (int i = 0; i < RAND_FETCHES; i++) begin
      tag = $urandom_range(2, 0) + 32'h40;  // three tags over four indexes
      idx = $urandom_range(3, 0);
      issue_fetch((tag << TAG_LSB) | (idx << OFFSET_W) | ($urandom_range(3, 0) << 2));
    end
    end_test("conflict");

    begin_test();
    bp_enable = 1'b1;
    for (int i = 0; i < RAND_FETCHES; i++) begin
      issue_fetch(32'h1000 + ($urandom_range(127, 0) << 2));
    end
    end_test("backpressure");
    bp_enable = 1'b0;

    begin_test();
    i_flush      = 1'b1;
    shadow_valid = '0;
    @(negedge clk);
    i_flush = 1'b0;
    for (int i = 0; i < SEQ_FETCHES; i++) begin
      issue_fetch(32'h1000 + 32'(i * 4));
    end
    end_test("flush");

    $display("%0d tests run, %0d with errors, %0d errors, %0d bursts",
             tests_run, tests_failed, err_count, ar_count);
    if (err_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- verif/axi_rom_model.sv
`timescale 1ns/10ps

module axi_rom_model (
  input  logic               clk,
  input  logic               nrst,
  input  fetch_pkg::axi_ar_t i_ar,
  input  logic               i_ar_valid,
  output logic               o_ar_ready,
  output fetch_pkg::axi_r_t  o_r,
  output logic               o_r_valid,
  input  logic               i_r_ready
);

  function automatic logic [31:0] rom_word(input logic [31:0] addr);
    logic [31:0] x;
    x = {addr[31:2], 2'b00} ^ 32'h1357_9bdf;
    return {x[26:0], x[31:27]};  // rotate left by 5
  endfunction

  initial begin : serve_bursts
    fetch_pkg::axi_ar_t ar;
    int unsigned        gap;
    int                 beat;
    o_ar_ready = 1'b0;
    o_r_valid  = 1'b0;
    o_r        = '0;
    forever begin
      @(negedge clk);
      if (nrst && i_ar_valid) begin
        gap = $urandom_range(3, 0);
        repeat (gap) @(negedge clk);
        ar         = i_ar;
        o_ar_ready = 1'b1;  // taken at the next rising edge
        @(negedge clk);
        o_ar_ready = 1'b0;
        for (beat = 0; beat <= int'(ar.len); beat++) begin
          gap = $urandom_range(2, 0);
          repeat (gap) @(negedge clk);
          o_r.data  = rom_word(ar.addr + 32'(beat * 4));
          o_r.id    = ar.id;
          o_r.resp  = 2'b00;
          o_r.last  = (beat == int'(ar.len));
          o_r_valid = 1'b1;
          while (!i_r_ready) @(negedge clk);
          @(negedge clk);
          o_r_valid = 1'b0;
        end
      end
    end
  end

endmodule

//--- design/fetch_top.sv
`timescale 1ns/10ps

`include "fetch_defines.svh"

module fetch_top #(
  parameter logic [`AXI_ID_W-1:0] AXI_ID = '0
) (
  input  logic                  clk,
  input  logic                  nrst,
  input  fetch_pkg::fetch_req_t i_req,
  input  logic                  i_req_valid,
  output logic                  o_req_ready,
  output fetch_pkg::fetch_rsp_t o_rsp,
  output logic                  o_rsp_valid,
  input  logic                  i_rsp_ready,
  input  logic                  i_flush,
  output fetch_pkg::axi_ar_t    o_ar,
  output logic                  o_ar_valid,
  input  logic                  i_ar_ready,
  input  fetch_pkg::axi_r_t     i_r,
  input  logic                  i_r_valid,
  output logic                  o_r_ready
);

  fetch_pkg::fetch_req_t   lookup;
  logic                    lookup_valid;
  logic                    lookup_ready;
  fetch_pkg::fetch_rsp_t   hit;
  logic                    hit_valid;
  logic                    miss;
  logic [31:0]             miss_addr;
  logic                    fill_done;
  fetch_pkg::icache_line_t fill_line;

  fetch_ifu fetch_ifu_i (
    .clk            (clk),
    .nrst           (nrst),
    .i_req          (i_req),
    .i_req_valid    (i_req_valid),
    .o_req_ready    (o_req_ready),
    .o_rsp          (o_rsp),
    .o_rsp_valid    (o_rsp_valid),
    .i_rsp_ready    (i_rsp_ready),
    .o_lookup       (lookup),
    .o_lookup_valid (lookup_valid),
    .i_lookup_ready (lookup_ready),
    .i_hit          (hit),
    .i_hit_valid    (hit_valid)
  );

  icache icache_i (
    .clk            (clk),
    .nrst           (nrst),
    .i_lookup       (lookup),
    .i_lookup_valid (lookup_valid),
    .o_lookup_ready (lookup_ready),
    .o_hit          (hit),
    .o_hit_valid    (hit_valid),
    .i_flush        (i_flush),
    .o_miss         (miss),
    .o_miss_addr    (miss_addr),
    .i_fill_done    (fill_done),
    .i_fill_line    (fill_line)
  );

  icache_refill #(
    .AXI_ID (AXI_ID)
  ) icache_refill_i (
    .clk         (clk),
    .nrst        (nrst),
    .i_miss      (miss),
    .i_miss_addr (miss_addr),
    .o_fill_done (fill_done),
    .o_fill_line (fill_line),
    .o_ar        (o_ar),
    .o_ar_valid  (o_ar_valid),
    .i_ar_ready  (i_ar_ready),
    .i_r         (i_r),
    .i_r_valid   (i_r_valid),
    .o_r_ready   (o_r_ready)
  );

endmodule

//--- design/icache_refill.sv
`timescale 1ns/10ps

`include "fetch_defines.svh"

module icache_refill #(
  parameter logic [`AXI_ID_W-1:0] AXI_ID = '0
) (
  input  logic                    clk,
  input  logic                    nrst,
  input  logic                    i_miss,
  input  logic [31:0]             i_miss_addr,
  output logic                    o_fill_done,
  output fetch_pkg::icache_line_t o_fill_line,
  output fetch_pkg::axi_ar_t      o_ar,
  output logic                    o_ar_valid,
  input  logic                    i_ar_ready,
  input  fetch_pkg::axi_r_t       i_r,
  input  logic                    i_r_valid,
  output logic                    o_r_ready
);

  localparam int BEAT_LOG2 = $clog2(`AXI_DATA_W / 8);
  localparam int OFFSET_W  = $clog2(`ICACHE_WORDS) + BEAT_LOG2;

  logic                    ar_valid_q;
  logic                    r_ready_q;
  logic                    done_q;
  logic [31:0]             addr_q;
  fetch_pkg::icache_line_t line_q;
  logic                    busy;
  logic                    beat;

  assign busy = ar_valid_q | r_ready_q;
  assign beat = i_r_valid & r_ready_q;

  always_comb begin
    o_ar.addr  = addr_q;
    o_ar.id    = AXI_ID;
    o_ar.len   = 8'(`ICACHE_WORDS - 1);
    o_ar.size  = 3'(BEAT_LOG2);
    o_ar.burst = fetch_pkg::AXI_BURST_INCR;
  end

  assign o_ar_valid  = ar_valid_q;
  assign o_r_ready   = r_ready_q;
  assign o_fill_done = done_q;
  assign o_fill_line = line_q;

  always_ff @(posedge clk) begin
    if (!nrst) begin
      ar_valid_q <= 1'b0;
      r_ready_q  <= 1'b0;
      done_q     <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (i_miss && !busy) begin
        ar_valid_q <= 1'b1;
      end
      if (ar_valid_q && i_ar_ready) begin
        ar_valid_q <= 1'b0;
        r_ready_q  <= 1'b1;  // burst in flight
      end
      if (beat && i_r.last) begin
        r_ready_q <= 1'b0;
        done_q    <= 1'b1;
      end
    end
  end

  // beats enter at the top, so the first one ends up in word 0
  always_ff @(posedge clk) begin
    if (i_miss && !busy) begin
      addr_q <= {i_miss_addr[31:OFFSET_W], {OFFSET_W{1'b0}}};
    end
    if (beat) begin
      line_q.words <= {i_r.data, line_q.words[`ICACHE_WORDS-1:1]};
    end
  end

endmodule

//--- design/icache.sv
`timescale 1ns/10ps

`include "fetch_defines.svh"

module icache (
  input  logic                    clk,
  input  logic                    nrst,
  input  fetch_pkg::fetch_req_t   i_lookup,
  input  logic                    i_lookup_valid,
  output logic                    o_lookup_ready,
  output fetch_pkg::fetch_rsp_t   o_hit,
  output logic                    o_hit_valid,
  input  logic                    i_flush,
  output logic                    o_miss,
  output logic [31:0]             o_miss_addr,
  input  logic                    i_fill_done,
  input  fetch_pkg::icache_line_t i_fill_line
);

  localparam int LINES    = 1 << `ICACHE_INDEX_W;
  localparam int WSEL_W   = $clog2(`ICACHE_WORDS);
  localparam int WSEL_LO  = $clog2(`FETCH_XLEN / 8);
  localparam int OFFSET_W = WSEL_W + WSEL_LO;
  localparam int TAG_W    = `FETCH_XLEN - `ICACHE_INDEX_W - OFFSET_W;

  typedef enum logic [1:0] {S_IDLE, S_LOOKUP, S_FILL} state_t;

  state_t                  state_q;
  logic                    flush_pend_q;
  logic                    miss_q;
  logic [LINES-1:0]        valid_q;
  fetch_pkg::fetch_req_t   pc_q;
  logic [TAG_W-1:0]        tag_mem [LINES];
  fetch_pkg::icache_line_t data_mem [LINES];

  logic [TAG_W-1:0]           pc_tag;
  logic [`ICACHE_INDEX_W-1:0] pc_idx;
  logic [WSEL_W-1:0]          pc_wsel;
  fetch_pkg::icache_line_t    rd_line;
  logic                       hit;
  logic                       flush_now;
  logic                       fill_wr;

  always_comb begin
    pc_tag    = pc_q.pc[`FETCH_XLEN-1 -: TAG_W];
    pc_idx    = pc_q.pc[OFFSET_W +: `ICACHE_INDEX_W];
    pc_wsel   = pc_q.pc[WSEL_LO +: WSEL_W];
    rd_line   = data_mem[pc_idx];
    hit       = (state_q == S_LOOKUP) && valid_q[pc_idx] && (tag_mem[pc_idx] == pc_tag);
    flush_now = i_flush | flush_pend_q;
    fill_wr   = (state_q == S_FILL) && i_fill_done;
  end

  assign o_lookup_ready = state_q == S_IDLE;
  assign o_hit_valid    = hit;
  assign o_hit.pc       = pc_q.pc;
  assign o_hit.inst     = rd_line.words[pc_wsel];
  assign o_miss         = miss_q;
  assign o_miss_addr    = {pc_q.pc[`FETCH_XLEN-1:OFFSET_W], {OFFSET_W{1'b0}}};  // line aligned

  always_ff @(posedge clk) begin
    if (!nrst) begin
      state_q      <= S_IDLE;
      flush_pend_q <= 1'b0;
      miss_q       <= 1'b0;
      valid_q      <= '0;
    end else begin
      miss_q <= 1'b0;
      case (state_q)
        S_IDLE: begin
          if (flush_now) begin
            valid_q      <= '0;
            flush_pend_q <= 1'b0;
          end
          if (i_lookup_valid) begin
            state_q <= S_LOOKUP;
          end
        end
        S_LOOKUP: begin
          if (hit) begin
            state_q <= S_IDLE;
            // the word is already out so a deferred flush lands now
            if (flush_now) begin
              valid_q      <= '0;
              flush_pend_q <= 1'b0;
            end
          end else begin
            miss_q  <= 1'b1;
            state_q <= S_FILL;
            if (i_flush) begin
              flush_pend_q <= 1'b1;
            end
          end
        end
        S_FILL: begin
          if (i_flush) begin
            flush_pend_q <= 1'b1;  // hold until the line is returned
          end
          if (i_fill_done) begin
            valid_q[pc_idx] <= 1'b1;
            state_q         <= S_LOOKUP;  // replay as a hit
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (o_lookup_ready && i_lookup_valid) begin
      pc_q <= i_lookup;
    end
    if (fill_wr) begin
      tag_mem[pc_idx]  <= pc_tag;
      data_mem[pc_idx] <= i_fill_line;
    end
  end

endmodule

//--- design/fetch_ifu.sv
`timescale 1ns/10ps

module fetch_ifu (
  input  logic                  clk,
  input  logic                  nrst,
  input  fetch_pkg::fetch_req_t i_req,
  input  logic                  i_req_valid,
  output logic                  o_req_ready,
  output fetch_pkg::fetch_rsp_t o_rsp,
  output logic                  o_rsp_valid,
  input  logic                  i_rsp_ready,
  output fetch_pkg::fetch_req_t o_lookup,
  output logic                  o_lookup_valid,
  input  logic                  i_lookup_ready,
  input  fetch_pkg::fetch_rsp_t i_hit,
  input  logic                  i_hit_valid
);

  // init keeps the core side closed for one cycle after reset
  typedef enum logic [1:0] {S_INIT, S_IDLE, S_WAIT, S_HOLD} state_t;

  state_t                state_q;
  fetch_pkg::fetch_rsp_t rsp_q;

  assign o_lookup       = i_req;
  assign o_lookup_valid = (state_q == S_IDLE) & i_req_valid;
  assign o_req_ready    = (state_q == S_IDLE) & i_lookup_ready;
  assign o_rsp          = rsp_q;
  assign o_rsp_valid    = state_q == S_HOLD;

  always_ff @(posedge clk) begin
    if (!nrst) begin
      state_q <= S_INIT;
    end else begin
      case (state_q)
        S_INIT: state_q <= S_IDLE;
        S_IDLE: begin
          if (i_req_valid && i_lookup_ready) begin
            state_q <= S_WAIT;  // one PC in flight
          end
        end
        S_WAIT: begin
          if (i_hit_valid) begin
            state_q <= S_HOLD;
          end
        end
        S_HOLD: begin
          if (i_rsp_ready) begin
            state_q <= S_IDLE;  // core took the word
          end
        end
        default: state_q <= S_INIT;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == S_WAIT && i_hit_valid) begin
      rsp_q <= i_hit;
    end
  end

endmodule

//--- design/fetch_pkg.sv
`include "fetch_defines.svh"

package fetch_pkg;

  localparam logic [1:0] AXI_BURST_INCR = 2'b01;

  typedef struct packed {
    logic [`FETCH_XLEN-1:0] pc;
  } fetch_req_t;

  typedef struct packed {
    logic [`FETCH_XLEN-1:0] pc;
    logic [`FETCH_XLEN-1:0] inst;
  } fetch_rsp_t;

  // word 0 sits in the low bits
  typedef struct packed {
    logic [`ICACHE_WORDS-1:0][`FETCH_XLEN-1:0] words;
  } icache_line_t;

  typedef struct packed {
    logic [31:0]           addr;
    logic [`AXI_ID_W-1:0]  id;
    logic [7:0]            len;   // beats minus one
    logic [2:0]            size;
    logic [1:0]            burst;
  } axi_ar_t;

  typedef struct packed {
    logic [`AXI_DATA_W-1:0] data;
    logic [`AXI_ID_W-1:0]   id;
    logic [1:0]             resp;
    logic                   last;
  } axi_r_t;

endpackage

//--- include/fetch_defines.svh
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// PC and instruction width
`define FETCH_XLEN 32

// the number of words per line also sets the burst length
`define ICACHE_WORDS 4
`define ICACHE_INDEX_W 6

// AXI read side
`define AXI_ID_W 4
`define AXI_DATA_W 32

`endif
